//--- verilog/exec_defines.svh
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// integer datapath width
`define XLEN 32

// shift amount taken from the low bits of operand b
`define SHAMT_W 5

`define REG_ADDR_W 5

// pc step for the link value
`define INSN_SIZE 4

`endif

//--- verilog/ExecTypes.sv
`default_nettype none

`include "exec_defines.svh"

package ExecTypes;

    typedef logic [`XLEN-1:0] word_t;

    typedef enum logic {
        UnitType_Alu,
        UnitType_MulDiv
    } UnitType;

    typedef enum logic [3:0] {
        AluCommand_Add,
        AluCommand_Sub,
        AluCommand_Sll,
        AluCommand_Slt,
        AluCommand_Sltu,
        AluCommand_Xor,
        AluCommand_Srl,
        AluCommand_Sra,
        AluCommand_Or,
        AluCommand_And
    } AluCommand;

    typedef enum logic [3:0] {
        MulDivCommand_Mul,
        MulDivCommand_Mulh,
        MulDivCommand_Mulhu,
        MulDivCommand_Div,
        MulDivCommand_Divu,
        MulDivCommand_Rem,
        MulDivCommand_Remu
    } MulDivCommand;

    // one command field, meaning depends on unitType
    typedef union packed {
        AluCommand    alu;
        MulDivCommand mulDiv;
    } ExecCommand;

    typedef enum logic [1:0] {
        AluSrc1Type_Zero,
        AluSrc1Type_Pc,
        AluSrc1Type_Reg
    } AluSrc1Type;

    typedef enum logic [1:0] {
        AluSrc2Type_Zero,
        AluSrc2Type_Imm,
        AluSrc2Type_Reg
    } AluSrc2Type;

    typedef enum logic [2:0] {
        BranchType_Equal,
        BranchType_NotEqual,
        BranchType_LessThan,
        BranchType_GreaterEqual,
        BranchType_UnsignedLessThan,
        BranchType_UnsignedGreaterEqual,
        BranchType_Always
    } BranchType;

    typedef enum logic {
        WriteSrcType_Result,
        WriteSrcType_NextPc
    } WriteSrcType;

    typedef struct packed {
        UnitType     unitType;
        ExecCommand  command;
        AluSrc1Type  aluSrc1;
        AluSrc2Type  aluSrc2;
        logic        isBranch;
        BranchType   branchType;
        WriteSrcType writeSrc;
        logic        regWrite;
        word_t       imm;
    } ExecOp;

endpackage

`default_nettype wire

//--- verilog/ExecStageIF.sv
`timescale 1ns/1ps
`default_nettype none

// operands after forwarding and source muxing
interface OperandIF;
    ExecTypes::word_t src1;
    ExecTypes::word_t src2;
    ExecTypes::word_t aluA;
    ExecTypes::word_t aluB;
    ExecTypes::ExecOp op;
    ExecTypes::word_t pc;

    modport producer (
        output src1, src2, aluA, aluB, op, pc
    );

    modport consumer (
        input src1, src2, aluA, aluB, op, pc
    );
endinterface

// unit results toward the output side
interface ExecResultIF;
    ExecTypes::word_t aluResult;
    logic             branchCond;
    ExecTypes::word_t mdResult;
    logic             mdDone;

    modport aluSide (
        output aluResult, branchCond
    );

    modport mdSide (
        output mdResult, mdDone
    );

    modport sink (
        input aluResult, branchCond, mdResult, mdDone
    );
endinterface

`default_nettype wire

//--- verilog/OperandSelect.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_defines.svh"

module OperandSelect (
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire logic                   inValid,
    input  ExecTypes::ExecOp            inOp,
    input  ExecTypes::word_t            inPc,
    input  ExecTypes::word_t            inSrc1,
    input  ExecTypes::word_t            inSrc2,
    input  wire logic [`REG_ADDR_W-1:0] inSrcAddr1,
    input  wire logic [`REG_ADDR_W-1:0] inSrcAddr2,
    input  wire logic                   fwdValid,
    input  wire logic [`REG_ADDR_W-1:0] fwdAddr,
    input  ExecTypes::word_t            fwdValue,
    OperandIF.producer                  opnd
);
    logic                   heldValid;
    logic [`REG_ADDR_W-1:0] heldAddr;
    ExecTypes::word_t       heldValue;
    logic                   bypValid;
    logic [`REG_ADDR_W-1:0] bypAddr;
    ExecTypes::word_t       bypValue;
    logic                   hit1;
    logic                   hit2;

    // keeps the last retired write visible across output bubbles
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            heldValid <= 1'b0;
        end else if (fwdValid) begin
            heldValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fwdValid) begin
            heldAddr  <= fwdAddr;
            heldValue <= fwdValue;
        end
    end

    always_comb begin
        bypValid = fwdValid || heldValid;
        bypAddr  = fwdValid ? fwdAddr : heldAddr;
        bypValue = fwdValid ? fwdValue : heldValue;

        // x0 is never forwarded
        hit1 = inValid && bypValid && (inSrcAddr1 != '0) && (inSrcAddr1 == bypAddr);
        hit2 = inValid && bypValid && (inSrcAddr2 != '0) && (inSrcAddr2 == bypAddr);

        opnd.src1 = hit1 ? bypValue : inSrc1;
        opnd.src2 = hit2 ? bypValue : inSrc2;
        opnd.op   = inOp;
        opnd.pc   = inPc;

        case (inOp.aluSrc1)
            ExecTypes::AluSrc1Type_Pc:  opnd.aluA = inPc;
            ExecTypes::AluSrc1Type_Reg: opnd.aluA = opnd.src1;
            default:                    opnd.aluA = '0;
        endcase

        case (inOp.aluSrc2)
            ExecTypes::AluSrc2Type_Imm: opnd.aluB = inOp.imm;
            ExecTypes::AluSrc2Type_Reg: opnd.aluB = opnd.src2;
            default:                    opnd.aluB = '0;
        endcase
    end
endmodule

`default_nettype wire

//--- verilog/IntAlu.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_defines.svh"

module IntAlu (
    OperandIF.consumer  opnd,
    ExecResultIF.aluSide res
);
    logic [`SHAMT_W-1:0] shamt;
    ExecTypes::word_t    a;
    ExecTypes::word_t    b;
    ExecTypes::word_t    s1;
    ExecTypes::word_t    s2;

    always_comb begin
        a     = opnd.aluA;
        b     = opnd.aluB;
        shamt = b[`SHAMT_W-1:0];

        case (opnd.op.command.alu)
            ExecTypes::AluCommand_Add:  res.aluResult = a + b;
            ExecTypes::AluCommand_Sub:  res.aluResult = a - b;
            ExecTypes::AluCommand_Sll:  res.aluResult = a << shamt;
            ExecTypes::AluCommand_Slt:  res.aluResult = {31'b0, $signed(a) < $signed(b)};
            ExecTypes::AluCommand_Sltu: res.aluResult = {31'b0, a < b};
            ExecTypes::AluCommand_Xor:  res.aluResult = a ^ b;
            ExecTypes::AluCommand_Srl:  res.aluResult = a >> shamt;
            ExecTypes::AluCommand_Sra:  res.aluResult = $signed(a) >>> shamt;
            ExecTypes::AluCommand_Or:   res.aluResult = a | b;
            ExecTypes::AluCommand_And:  res.aluResult = a & b;
            default:                    res.aluResult = '0;
        endcase
    end

    // compares the forwarded registers, not the muxed operands
    always_comb begin
        s1 = opnd.src1;
        s2 = opnd.src2;

        case (opnd.op.branchType)
            ExecTypes::BranchType_Equal:
                res.branchCond = (s1 == s2);
            ExecTypes::BranchType_NotEqual:
                res.branchCond = (s1 != s2);
            ExecTypes::BranchType_LessThan:
                res.branchCond = ($signed(s1) < $signed(s2));
            ExecTypes::BranchType_GreaterEqual:
                res.branchCond = ($signed(s1) >= $signed(s2));
            ExecTypes::BranchType_UnsignedLessThan:
                res.branchCond = (s1 < s2);
            ExecTypes::BranchType_UnsignedGreaterEqual:
                res.branchCond = (s1 >= s2);
            ExecTypes::BranchType_Always:
                res.branchCond = 1'b1;
            default:
                res.branchCond = 1'b0;
        endcase
    end
endmodule

`default_nettype wire

//--- verilog/MulDivUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_defines.svh"

module MulDivUnit (
    input  wire logic    clk,
    input  wire logic    rstN,
    input  wire logic    inValid,
    OperandIF.consumer   opnd,
    ExecResultIF.mdSide  res
);
    logic                      busy;
    logic [5:0]                count;
    ExecTypes::MulDivCommand   cmd;
    ExecTypes::MulDivCommand   inCmd;
    ExecTypes::word_t          opA;
    ExecTypes::word_t          opB;
    ExecTypes::word_t          absIn1;
    ExecTypes::word_t          absB;
    // rem in the upper half, quotient or product low word below
    logic [2*`XLEN-1:0]        acc;
    logic signed [2*`XLEN+1:0] mulFull;
    logic [`XLEN:0]            shifted;
    logic [`XLEN:0]            diff;
    logic                      start;
    logic                      inIsMul;
    logic                      inDivSigned;
    logic                      isMul;
    logic                      mulSigned;
    logic                      divSigned;
    logic                      negQ;
    logic                      negR;

    always_comb begin
        inCmd       = opnd.op.command.mulDiv;
        start       = inValid && (opnd.op.unitType == ExecTypes::UnitType_MulDiv) && !busy;
        inIsMul     = inCmd inside {ExecTypes::MulDivCommand_Mul, ExecTypes::MulDivCommand_Mulh,
                                    ExecTypes::MulDivCommand_Mulhu};
        inDivSigned = inCmd inside {ExecTypes::MulDivCommand_Div, ExecTypes::MulDivCommand_Rem};
        absIn1      = (inDivSigned && opnd.src1[`XLEN-1]) ? -opnd.src1 : opnd.src1;

        isMul     = cmd inside {ExecTypes::MulDivCommand_Mul, ExecTypes::MulDivCommand_Mulh,
                                ExecTypes::MulDivCommand_Mulhu};
        mulSigned = (cmd == ExecTypes::MulDivCommand_Mulh);
        divSigned = cmd inside {ExecTypes::MulDivCommand_Div, ExecTypes::MulDivCommand_Rem};
        absB      = (divSigned && opB[`XLEN-1]) ? -opB : opB;
        mulFull   = $signed({mulSigned & opA[`XLEN-1], opA}) *
                    $signed({mulSigned & opB[`XLEN-1], opB});

        // one restoring step
        shifted = {acc[2*`XLEN-1:`XLEN], acc[`XLEN-1]};
        diff    = shifted - {1'b0, absB};
    end

    // mul takes one step, div takes 32
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            count <= inIsMul ? 6'd1 : 6'd32;
        end else if (busy && count == '0) begin
            busy <= 1'b0;
        end else if (busy) begin
            count <= count - 6'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            cmd <= inCmd;
            opA <= opnd.src1;
            opB <= opnd.src2;
            acc <= {{`XLEN{1'b0}}, absIn1};
        end else if (busy && count != '0) begin
            if (isMul) begin
                acc <= mulFull[2*`XLEN-1:0];
            end else if (!diff[`XLEN]) begin
                acc <= {diff[`XLEN-1:0], acc[`XLEN-2:0], 1'b1};
            end else begin
                acc <= {shifted[`XLEN-1:0], acc[`XLEN-2:0], 1'b0};
            end
        end
    end

    // sign fix; overflow case falls out of the magnitudes
    always_comb begin
        negQ       = divSigned && (opA[`XLEN-1] ^ opB[`XLEN-1]);
        negR       = divSigned && opA[`XLEN-1];
        res.mdDone = busy && (count == '0);

        case (cmd)
            ExecTypes::MulDivCommand_Mul:
                res.mdResult = acc[`XLEN-1:0];
            ExecTypes::MulDivCommand_Mulh, ExecTypes::MulDivCommand_Mulhu:
                res.mdResult = acc[2*`XLEN-1:`XLEN];
            ExecTypes::MulDivCommand_Div, ExecTypes::MulDivCommand_Divu:
                if (opB == '0) begin
                    res.mdResult = '1;
                end else begin
                    res.mdResult = negQ ? -acc[`XLEN-1:0] : acc[`XLEN-1:0];
                end
            ExecTypes::MulDivCommand_Rem, ExecTypes::MulDivCommand_Remu:
                if (opB == '0) begin
                    res.mdResult = opA;
                end else begin
                    res.mdResult = negR ? -acc[2*`XLEN-1:`XLEN] : acc[2*`XLEN-1:`XLEN];
                end
            default:
                res.mdResult = '0;
        endcase
    end
endmodule

`default_nettype wire

//--- verilog/ResultStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_defines.svh"

module ResultStage (
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire logic                   inValid,
    input  wire logic [`REG_ADDR_W-1:0] inDstAddr,
    OperandIF.consumer                  opnd,
    ExecResultIF.sink                   res,
    output logic                        stall,
    output logic                        outValid,
    output logic                        outRegWrite,
    output logic [`REG_ADDR_W-1:0]      outDstAddr,
    output ExecTypes::word_t            outDstValue,
    output logic                        redirect,
    output ExecTypes::word_t            redirectPc,
    output logic                        fwdValid,
    output logic [`REG_ADDR_W-1:0]      fwdAddr,
    output ExecTypes::word_t            fwdValue
);
    logic             isMulDiv;
    logic             retire;
    logic             taken;
    ExecTypes::word_t unitResult;
    ExecTypes::word_t dstValue;

    always_comb begin
        isMulDiv = (opnd.op.unitType == ExecTypes::UnitType_MulDiv);
        stall    = inValid && isMulDiv && !res.mdDone;
        retire   = inValid && !stall;
        taken    = opnd.op.isBranch && res.branchCond;

        unitResult = isMulDiv ? res.mdResult : res.aluResult;
        if (opnd.op.writeSrc == ExecTypes::WriteSrcType_NextPc) begin
            dstValue = opnd.pc + `INSN_SIZE;
        end else begin
            dstValue = unitResult;
        end
    end

    // a stalled op leaves a bubble behind
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid    <= 1'b0;
            outRegWrite <= 1'b0;
            redirect    <= 1'b0;
        end else begin
            outValid    <= retire;
            outRegWrite <= retire && opnd.op.regWrite;
            redirect    <= retire && taken;
        end
    end

    always_ff @(posedge clk) begin
        outDstAddr  <= inDstAddr;
        outDstValue <= dstValue;
        // branch target comes from the ALU (pc + imm)
        redirectPc  <= res.aluResult;
    end

    always_comb begin
        fwdValid = outValid && outRegWrite;
        fwdAddr  = outDstAddr;
        fwdValue = outDstValue;
    end
endmodule

`default_nettype wire

//--- verilog/ExecTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_defines.svh"

module ExecTop (
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire logic                   inValid,
    input  ExecTypes::ExecOp            inOp,
    input  ExecTypes::word_t            inPc,
    input  ExecTypes::word_t            inSrc1,
    input  ExecTypes::word_t            inSrc2,
    input  wire logic [`REG_ADDR_W-1:0] inSrcAddr1,
    input  wire logic [`REG_ADDR_W-1:0] inSrcAddr2,
    input  wire logic [`REG_ADDR_W-1:0] inDstAddr,
    output logic                        stall,
    output logic                        outValid,
    output logic                        outRegWrite,
    output logic [`REG_ADDR_W-1:0]      outDstAddr,
    output ExecTypes::word_t            outDstValue,
    output logic                        redirect,
    output ExecTypes::word_t            redirectPc
);
    logic                   fwdValid;
    logic [`REG_ADDR_W-1:0] fwdAddr;
    ExecTypes::word_t       fwdValue;

    OperandIF    opndIf ();
    ExecResultIF resIf ();

    OperandSelect uOperandSelect (
        .clk        (clk),
        .rstN       (rstN),
        .inValid    (inValid),
        .inOp       (inOp),
        .inPc       (inPc),
        .inSrc1     (inSrc1),
        .inSrc2     (inSrc2),
        .inSrcAddr1 (inSrcAddr1),
        .inSrcAddr2 (inSrcAddr2),
        .fwdValid   (fwdValid),
        .fwdAddr    (fwdAddr),
        .fwdValue   (fwdValue),
        .opnd       (opndIf.producer)
    );

    IntAlu uIntAlu (
        .opnd (opndIf.consumer),
        .res  (resIf.aluSide)
    );

    MulDivUnit uMulDivUnit (
        .clk     (clk),
        .rstN    (rstN),
        .inValid (inValid),
        .opnd    (opndIf.consumer),
        .res     (resIf.mdSide)
    );

    ResultStage uResultStage (
        .clk         (clk),
        .rstN        (rstN),
        .inValid     (inValid),
        .inDstAddr   (inDstAddr),
        .opnd        (opndIf.consumer),
        .res         (resIf.sink),
        .stall       (stall),
        .outValid    (outValid),
        .outRegWrite (outRegWrite),
        .outDstAddr  (outDstAddr),
        .outDstValue (outDstValue),
        .redirect    (redirect),
        .redirectPc  (redirectPc),
        .fwdValid    (fwdValid),
        .fwdAddr     (fwdAddr),
        .fwdValue    (fwdValue)
    );
endmodule

`default_nettype wire

//--- verification/exec_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module ExecAssertions (
    input wire logic clk,
    input wire logic rstN,
    input wire logic stall,
    input wire logic outValid,
    input wire logic outRegWrite,
    input wire logic redirect
);
    // output register comes out of reset empty
    quietAfterReset: assert property (@(posedge clk)
        $rose(rstN) |-> !outValid && !outRegWrite && !redirect)
        else $error("output register active in the first cycle after reset");

    redirectNeedsValid: assert property (@(posedge clk) disable iff (!rstN)
        redirect |-> outValid)
        else $error("redirect raised without outValid");

    // a stalled cycle leaves a bubble
    stallGivesBubble: assert property (@(posedge clk) disable iff (!rstN)
        stall |=> !outValid)
        else $error("outValid high in the cycle after a stall");
endmodule

bind ExecTop ExecAssertions uAssertions (
    .clk         (clk),
    .rstN        (rstN),
    .stall       (stall),
    .outValid    (outValid),
    .outRegWrite (outRegWrite),
    .redirect    (redirect)
);

`default_nettype wire

//--- verification/tb_exec.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_defines.svh"

module tb_exec;
    localparam int NumOps     = 400;
    localparam int StallLimit = 100;

    logic                   clk;
    logic                   rstN;
    logic                   inValid;
    ExecTypes::ExecOp       inOp;
    ExecTypes::word_t       inPc;
    ExecTypes::word_t       inSrc1;
    ExecTypes::word_t       inSrc2;
    logic [`REG_ADDR_W-1:0] inSrcAddr1;
    logic [`REG_ADDR_W-1:0] inSrcAddr2;
    logic [`REG_ADDR_W-1:0] inDstAddr;
    logic                   stall;
    logic                   outValid;
    logic                   outRegWrite;
    logic [`REG_ADDR_W-1:0] outDstAddr;
    ExecTypes::word_t       outDstValue;
    logic                   redirect;
    ExecTypes::word_t       redirectPc;

    logic [31:0]            seed;
    logic [31:0]            regs [32];
    int                     errors;
    int                     checks;
    bit                     timedOut;
    // most recent retired write is kept out of the driven sources
    logic [`REG_ADDR_W-1:0] lastAddr;
    logic [31:0]            lastOld;

    ExecTop uut (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] nextRandom();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %0t ns: %s is %08h, expected %08h", $time, what, actual, expected);
        end
    endtask

    function automatic logic [31:0] staleReg(logic [`REG_ADDR_W-1:0] addr);
        if (addr != '0 && addr == lastAddr) begin
            return lastOld;
        end
        return regs[addr];
    endfunction

    function automatic bit branchTaken(ExecTypes::BranchType bt, logic [31:0] s1,
                                       logic [31:0] s2);
        case (bt)
            ExecTypes::BranchType_Equal:                return s1 == s2;
            ExecTypes::BranchType_NotEqual:             return s1 != s2;
            ExecTypes::BranchType_LessThan:             return $signed(s1) < $signed(s2);
            ExecTypes::BranchType_GreaterEqual:         return $signed(s1) >= $signed(s2);
            ExecTypes::BranchType_UnsignedLessThan:     return s1 < s2;
            ExecTypes::BranchType_UnsignedGreaterEqual: return s1 >= s2;
            default:                                    return 1'b1;
        endcase
    endfunction

    // reference result straight from the RV32IM rules
    function automatic logic [31:0] expectResult(ExecTypes::ExecOp op, logic [31:0] s1,
                                                 logic [31:0] s2, logic [31:0] pc);
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] prod;
        logic        ovf;
        a   = (op.aluSrc1 == ExecTypes::AluSrc1Type_Pc) ? pc :
              (op.aluSrc1 == ExecTypes::AluSrc1Type_Reg) ? s1 : 32'd0;
        b   = (op.aluSrc2 == ExecTypes::AluSrc2Type_Imm) ? op.imm :
              (op.aluSrc2 == ExecTypes::AluSrc2Type_Reg) ? s2 : 32'd0;
        ovf = (s1 == 32'h8000_0000) && (s2 == 32'hffff_ffff);
        if (op.writeSrc == ExecTypes::WriteSrcType_NextPc) begin
            return pc + 32'd4;
        end
        if (op.unitType == ExecTypes::UnitType_Alu) begin
            case (op.command.alu)
                ExecTypes::AluCommand_Add:  return a + b;
                ExecTypes::AluCommand_Sub:  return a - b;
                ExecTypes::AluCommand_Sll:  return a << b[4:0];
                ExecTypes::AluCommand_Slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                ExecTypes::AluCommand_Sltu: return (a < b) ? 32'd1 : 32'd0;
                ExecTypes::AluCommand_Xor:  return a ^ b;
                ExecTypes::AluCommand_Srl:  return a >> b[4:0];
                ExecTypes::AluCommand_Sra:  return $signed(a) >>> b[4:0];
                ExecTypes::AluCommand_Or:   return a | b;
                default:                    return a & b;
            endcase
        end
        case (op.command.mulDiv)
            ExecTypes::MulDivCommand_Mul: return s1 * s2;
            ExecTypes::MulDivCommand_Mulh: begin
                prod = $signed({{32{s1[31]}}, s1}) * $signed({{32{s2[31]}}, s2});
                return prod[63:32];
            end
            ExecTypes::MulDivCommand_Mulhu: begin
                prod = {32'd0, s1} * {32'd0, s2};
                return prod[63:32];
            end
            ExecTypes::MulDivCommand_Div: begin
                if (s2 == 0) begin
                    return 32'hffff_ffff;
                end
                if (ovf) begin
                    return s1;
                end
                return $signed(s1) / $signed(s2);
            end
            ExecTypes::MulDivCommand_Divu: return (s2 == 0) ? 32'hffff_ffff : s1 / s2;
            ExecTypes::MulDivCommand_Rem: begin
                if (s2 == 0) begin
                    return s1;
                end
                if (ovf) begin
                    return 32'd0;
                end
                return $signed(s1) % $signed(s2);
            end
            default:                       return (s2 == 0) ? s1 : s1 % s2;
        endcase
    endfunction

    initial begin
        ExecTypes::ExecOp       op;
        logic [31:0]            r;
        logic [31:0]            pc;
        logic [31:0]            expected;
        logic [`REG_ADDR_W-1:0] a1;
        logic [`REG_ADDR_W-1:0] a2;
        logic [`REG_ADDR_W-1:0] dst;
        bit                     taken;
        int                     stallCycles;
        int                     expCycles;

        clk        = 1'b0;
        rstN       = 1'b0;
        inValid    = 1'b0;
        inOp       = '0;
        inPc       = '0;
        inSrc1     = '0;
        inSrc2     = '0;
        inSrcAddr1 = '0;
        inSrcAddr2 = '0;
        inDstAddr  = '0;
        seed       = 32'd74;
        errors     = 0;
        checks     = 0;
        timedOut   = 1'b0;
        lastAddr   = '0;
        lastOld    = '0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = (i == 0) ? 32'd0 : nextRandom();
        end
        // x1 and x2 stay unwritten and give the signed overflow pair
        regs[1] = 32'h8000_0000;
        regs[2] = 32'hffff_ffff;

        repeat (3) @(posedge clk);
        #1 rstN = 1'b1;
        repeat (2) begin
            #1;
            checkValue({31'b0, outValid}, 32'd0, "outValid after reset");
            checkValue({31'b0, redirect}, 32'd0, "redirect after reset");
            @(posedge clk);
        end
        #1;

        for (int n = 0; n < NumOps; n++) begin
            r           = nextRandom();
            op          = '0;
            op.imm      = nextRandom();
            op.regWrite = r[0];
            op.aluSrc1  = ExecTypes::AluSrc1Type'(r[9:8] % 2'd3);
            op.aluSrc2  = ExecTypes::AluSrc2Type'(r[11:10] % 2'd3);
            pc          = nextRandom() & ~32'd3;
            if (r[3:1] < 3'd4) begin
                op.unitType    = ExecTypes::UnitType_Alu;
                op.command.alu = ExecTypes::AluCommand'(r[7:4] % 4'd10);
            end else if (r[3:1] < 3'd6) begin
                op.unitType       = ExecTypes::UnitType_MulDiv;
                op.command.mulDiv = ExecTypes::MulDivCommand'(r[7:4] % 4'd7);
            end else begin
                op.unitType    = ExecTypes::UnitType_Alu;
                op.command.alu = ExecTypes::AluCommand_Add;
                op.aluSrc1     = ExecTypes::AluSrc1Type_Pc;
                op.aluSrc2     = ExecTypes::AluSrc2Type_Imm;
                op.isBranch    = 1'b1;
                op.branchType  = ExecTypes::BranchType'(r[6:4] % 3'd7);
                op.writeSrc    = ExecTypes::WriteSrcType_NextPc;
            end
            // small register range so forwarding and x0 cases come up often
            if (op.unitType == ExecTypes::UnitType_MulDiv) begin
                a1 = {3'b0, r[17:16]};
                a2 = {3'b0, r[19:18]};
            end else begin
                a1 = {2'b0, r[18:16]};
                a2 = {2'b0, r[21:19]};
            end
            dst = {2'b0, r[24:22]};
            if (dst == 5'd1 || dst == 5'd2) begin
                dst = dst + 5'd4;
            end

            expected  = expectResult(op, regs[a1], regs[a2], pc);
            taken     = op.isBranch && branchTaken(op.branchType, regs[a1], regs[a2]);
            expCycles = 0;
            if (op.unitType == ExecTypes::UnitType_MulDiv) begin
                expCycles = (op.command.mulDiv inside {ExecTypes::MulDivCommand_Mul,
                    ExecTypes::MulDivCommand_Mulh, ExecTypes::MulDivCommand_Mulhu}) ? 2 : 33;
            end

            inValid    = 1'b1;
            inOp       = op;
            inPc       = pc;
            inSrcAddr1 = a1;
            inSrcAddr2 = a2;
            inSrc1     = staleReg(a1);
            inSrc2     = staleReg(a2);
            inDstAddr  = dst;
            #1;
            stallCycles = 0;
            while (stall && !timedOut) begin
                @(posedge clk);
                #2;
                stallCycles++;
                checkValue({31'b0, outValid}, 32'd0, "outValid during stall");
                if (stallCycles > StallLimit) begin
                    $display("timeout: stall stayed high for more than %0d cycles", StallLimit);
                    timedOut = 1'b1;
                end
            end
            if (timedOut) begin
                break;
            end
            checkValue(stallCycles, expCycles, "stall cycles");

            @(posedge clk);
            #1;
            checkValue({31'b0, outValid}, 32'd1, "outValid");
            checkValue({31'b0, outRegWrite}, {31'b0, op.regWrite}, "outRegWrite");
            checkValue({27'b0, outDstAddr}, {27'b0, dst}, "outDstAddr");
            checkValue(outDstValue, expected, "outDstValue");
            checkValue({31'b0, redirect}, {31'b0, taken}, "redirect");
            if (taken) begin
                checkValue(redirectPc, pc + op.imm, "redirectPc");
            end
            // a write to x0 still replaces the DUT's last forwarded write
            if (outValid && outRegWrite) begin
                lastAddr = dst;
                lastOld  = regs[dst];
                if (dst != '0) begin
                    regs[dst] = expected;
                end
            end
        end
        inValid = 1'b0;

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && !timedOut) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end
endmodule

`default_nettype wire

//--- filelist.f
+incdir+verilog
verilog/ExecTypes.sv
verilog/ExecStageIF.sv
verilog/OperandSelect.sv
verilog/IntAlu.sv
verilog/MulDivUnit.sv
verilog/ResultStage.sv
verilog/ExecTop.sv
verification/exec_assertions.sv
verification/tb_exec.sv

//--- run.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_exec -f filelist.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_exec)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1
